// ==== filelist.f ====
+incdir+hw
hw/io_pkg.sv
hw/io_addr_decoder.sv
hw/bram_line_store.sv
hw/host_mailbox.sv
hw/io_subsys_top.sv
dv/io_subsys_tb.sv

// ==== Makefile ====
TOP := io_subsys_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the directed tests"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== dv/io_subsys_tb.sv ====
// directed tests only, each response due one cycle after its request; RAM read only where written
`timescale 1ns/1ps
`include "io_config.svh"

module io_subsys_tb;

   localparam int CLK_PERIOD = 10;
   localparam int N_REQ      = 32 + 24 + 2 + 5 + 24;   // requests per test, in run order
   localparam int WD_CYCLES  = N_REQ*20 + 200;          // margin for reset and idle cycles

   logic                      ram_clk;
   logic                      rst_n_i;
   logic                      req_valid_i;
   io_pkg::io_req_t           req_i;
   logic                      rsp_valid_o;
   io_pkg::io_rsp_t           rsp_o;
   logic                      tohost_valid_o;
   logic [`IO_DATA_WIDTH-1:0] tohost_o;
   logic                      fromhost_valid_i;
   logic [`IO_DATA_WIDTH-1:0] fromhost_i;
   logic                      irq_o;

   int              err_cnt;
   int              test_errs;   // error count when the test began
   int              test_cnt;
   string           cur_test;
   logic            pend;        // response due at the next sample
   io_pkg::io_rsp_t pend_exp;
   logic [`IO_DATA_WIDTH-1:0] ram_model [int];   // byte address -> word
   int              used_lines [4] = '{0, 1, 37, 255};

   io_subsys_top u_dut (
      .ram_clk          ( ram_clk          ),
      .rst_n_i          ( rst_n_i          ),
      .req_valid_i      ( req_valid_i      ),
      .req_i            ( req_i            ),
      .rsp_valid_o      ( rsp_valid_o      ),
      .rsp_o            ( rsp_o            ),
      .tohost_valid_o   ( tohost_valid_o   ),
      .tohost_o         ( tohost_o         ),
      .fromhost_valid_i ( fromhost_valid_i ),
      .fromhost_i       ( fromhost_i       ),
      .irq_o            ( irq_o            )
   );

   initial begin
      ram_clk = 1'b0;
      forever #(CLK_PERIOD/2) ram_clk = ~ram_clk;
   end

   initial begin
      #(WD_CYCLES*CLK_PERIOD);
      $display("watchdog timeout after %0d cycles, test %s never finished", WD_CYCLES, cur_test);
      $display("SIMULATION FAILED");
      $finish;
   end

   //////////////////////////////////////////////////////////////
   // request building and reference model

   function automatic io_pkg::io_req_t make_req(io_pkg::io_op_e op,
                                                logic [`IO_ADDR_WIDTH-1:0] addr,
                                                logic [`IO_DATA_WIDTH-1:0] wdata,
                                                logic [`IO_STRB_WIDTH-1:0] strb);
      io_pkg::io_req_t r;
      r.op    = op;
      r.addr  = addr;
      r.wdata = wdata;
      r.strb  = strb;
      return r;
   endfunction

   function automatic io_pkg::io_rsp_t make_rsp(logic [`IO_DATA_WIDTH-1:0] rdata, logic err);
      io_pkg::io_rsp_t r;
      r.rdata = rdata;
      r.err   = err;
      return r;
   endfunction

   function automatic logic [`IO_ADDR_WIDTH-1:0] bram_addr(int line, int lane);
      return `BRAM_BASE + 32'(line*(`BRAM_LINE_WIDTH/8) + lane*(`IO_DATA_WIDTH/8));
   endfunction

   function automatic logic [`IO_ADDR_WIDTH-1:0] mbox_addr(int word);
      return `HOST_BASE + 32'(word*(`IO_DATA_WIDTH/8));
   endfunction

   // enabled bytes come from the new word
   function automatic logic [`IO_DATA_WIDTH-1:0] merge_bytes(logic [`IO_DATA_WIDTH-1:0] old_w,
                                                             logic [`IO_DATA_WIDTH-1:0] new_w,
                                                             logic [`IO_STRB_WIDTH-1:0] strb);
      logic [`IO_DATA_WIDTH-1:0] m;
      m = old_w;
      for (int i = 0; i < `IO_STRB_WIDTH; i++) begin
         if (strb[i]) begin
            m[i*8 +: 8] = new_w[i*8 +: 8];
         end
      end
      return m;
   endfunction

   function automatic logic [`IO_STRB_WIDTH-1:0] rand_strb();
      logic [`IO_STRB_WIDTH-1:0] s;
      s = '0;
      while (s == '0) begin
         s = `IO_STRB_WIDTH'($urandom);
      end
      return s;
   endfunction

   //////////////////////////////////////////////////////////////
   // compare tasks

   task automatic check_rsp(io_pkg::io_rsp_t exp, io_pkg::io_rsp_t act);
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s: expected rdata %h err %b, actual rdata %h err %b",
                  cur_test, exp.rdata, exp.err, act.rdata, act.err);
      end
   endtask

   task automatic check_word(string what, logic [`IO_DATA_WIDTH-1:0] exp,
                             logic [`IO_DATA_WIDTH-1:0] act);
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s (%s): expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_flag(string what, logic exp, logic act);
      if (act !== exp) begin
         err_cnt++;
         $display("Fail %s (%s): expected %b, actual %b", cur_test, what, exp, act);
      end
   endtask

   //////////////////////////////////////////////////////////////
   // bus driving, one call per clock cycle

   // checks the request driven one edge earlier
   task automatic sample_rsp();
      @(negedge ram_clk);
      if (pend) begin
         if (rsp_valid_o !== 1'b1) begin
            err_cnt++;
            $display("%s: no response strobe one cycle after the request", cur_test);
         end else begin
            check_rsp(pend_exp, rsp_o);
         end
      end else if (rsp_valid_o !== 1'b0) begin
         err_cnt++;
         $display("%s: response strobe high with no request in flight", cur_test);
      end
   endtask

   task automatic send_req(io_pkg::io_req_t r, io_pkg::io_rsp_t exp);
      @(posedge ram_clk);
      req_valid_i      <= 1'b1;
      req_i            <= r;
      fromhost_valid_i <= 1'b0;
      sample_rsp();
      pend     = 1'b1;
      pend_exp = exp;
   endtask

   task automatic idle_cycle();
      @(posedge ram_clk);
      req_valid_i      <= 1'b0;
      req_i            <= '0;
      fromhost_valid_i <= 1'b0;
      sample_rsp();
      pend = 1'b0;
   endtask

   task automatic load_fromhost(logic [`IO_DATA_WIDTH-1:0] v);
      @(posedge ram_clk);
      req_valid_i      <= 1'b0;
      fromhost_valid_i <= 1'b1;
      fromhost_i       <= v;
      sample_rsp();
      pend = 1'b0;
   endtask

   task automatic start_test(string name);
      cur_test  = name;
      test_errs = err_cnt;
      test_cnt++;
   endtask

   task automatic end_test();
      if (err_cnt == test_errs) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: %0d errors", cur_test, err_cnt - test_errs);
      end
   endtask

   //////////////////////////////////////////////////////////////
   // directed tests

   task automatic test_reset_idle();
      start_test("reset_idle");
      repeat (6) begin
         idle_cycle();
         check_flag("tohost strobe", 1'b0, tohost_valid_o);
         check_flag("irq", 1'b0, irq_o);
      end
      check_word("tohost after reset", '0, tohost_o);
      end_test();
   endtask

   // whole lines written, then read back one per cycle
   task automatic test_full_words();
      logic [`IO_ADDR_WIDTH-1:0] addr;
      logic [`IO_DATA_WIDTH-1:0] data;
      start_test("full_words");
      foreach (used_lines[i]) begin
         for (int lane = 0; lane < `BRAM_LANES; lane++) begin
            addr = bram_addr(used_lines[i], lane);
            data = $urandom;
            ram_model[int'(addr)] = data;
            send_req(make_req(io_pkg::IO_WRITE, addr, data, '1), make_rsp('0, 1'b0));
         end
      end
      foreach (used_lines[i]) begin
         for (int lane = 0; lane < `BRAM_LANES; lane++) begin
            addr = bram_addr(used_lines[i], lane);
            send_req(make_req(io_pkg::IO_READ, addr, '0, '0),
                     make_rsp(ram_model[int'(addr)], 1'b0));
         end
      end
      idle_cycle();
      end_test();
   endtask

   task automatic test_partial_writes();
      logic [`IO_ADDR_WIDTH-1:0] addr;
      logic [`IO_DATA_WIDTH-1:0] data;
      logic [`IO_STRB_WIDTH-1:0] strb;
      start_test("partial_writes");
      repeat (12) begin
         addr = bram_addr(used_lines[int'($urandom_range(3, 0))], int'($urandom_range(3, 0)));
         data = $urandom;
         strb = rand_strb();
         ram_model[int'(addr)] = merge_bytes(ram_model[int'(addr)], data, strb);
         send_req(make_req(io_pkg::IO_WRITE, addr, data, strb), make_rsp('0, 1'b0));
         // read right behind the write
         send_req(make_req(io_pkg::IO_READ, addr, '0, '0),
                  make_rsp(ram_model[int'(addr)], 1'b0));
      end
      idle_cycle();
      end_test();
   endtask

   task automatic test_tohost();
      logic [`IO_ADDR_WIDTH-1:0] addr;
      logic [`IO_DATA_WIDTH-1:0] data;
      start_test("tohost");
      addr = mbox_addr(int'(io_pkg::MBOX_TOHOST));
      data = $urandom;
      // strobes ignored, whole word expected
      send_req(make_req(io_pkg::IO_WRITE, addr, data, 4'h3), make_rsp('0, 1'b0));
      check_flag("tohost strobe too early", 1'b0, tohost_valid_o);
      send_req(make_req(io_pkg::IO_READ, addr, '0, '0), make_rsp(data, 1'b0));
      if (tohost_valid_o !== 1'b1) begin
         err_cnt++;
         $display("%s: no tohost strobe one cycle after the write", cur_test);
      end
      check_word("tohost data", data, tohost_o);
      idle_cycle();
      check_flag("tohost strobe after pulse", 1'b0, tohost_valid_o);
      end_test();
   endtask

   task automatic test_fromhost();
      logic [`IO_ADDR_WIDTH-1:0] addr;
      logic [`IO_DATA_WIDTH-1:0] data;
      start_test("fromhost");
      addr = mbox_addr(int'(io_pkg::MBOX_FROMHOST));
      data = $urandom | 32'h1;   // never zero
      load_fromhost(data);
      check_flag("irq before load lands", 1'b0, irq_o);
      idle_cycle();
      check_flag("irq after load", 1'b1, irq_o);
      send_req(make_req(io_pkg::IO_READ, addr, '0, '0), make_rsp(data, 1'b0));
      check_flag("irq with read in flight", 1'b1, irq_o);
      send_req(make_req(io_pkg::IO_READ, addr, '0, '0), make_rsp('0, 1'b0));
      check_flag("irq after clearing read", 1'b0, irq_o);
      send_req(make_req(io_pkg::IO_WRITE, addr, 32'hA5A5_0001, '1), make_rsp('0, 1'b0));
      send_req(make_req(io_pkg::IO_READ, addr, '0, '0), make_rsp('0, 1'b0));
      check_flag("irq after bus write to fromhost", 1'b0, irq_o);
      send_req(make_req(io_pkg::IO_READ, mbox_addr(3), '0, '0), make_rsp('0, 1'b0));
      idle_cycle();
      end_test();
   endtask

   // misses answer with err, RAM keeps its words
   task automatic test_miss();
      logic [`IO_ADDR_WIDTH-1:0] miss_addr [4];
      logic [`IO_ADDR_WIDTH-1:0] addr;
      start_test("miss");
      miss_addr = '{32'h0000_0000, 32'h0001_1000, 32'h0000_1010, 32'hFFFF_FFF0};
      foreach (miss_addr[i]) begin
         send_req(make_req(io_pkg::IO_WRITE, miss_addr[i], $urandom, '1), make_rsp('0, 1'b1));
         send_req(make_req(io_pkg::IO_READ, miss_addr[i], '0, '0), make_rsp('0, 1'b1));
      end
      foreach (used_lines[i]) begin
         for (int lane = 0; lane < `BRAM_LANES; lane++) begin
            addr = bram_addr(used_lines[i], lane);
            send_req(make_req(io_pkg::IO_READ, addr, '0, '0),
                     make_rsp(ram_model[int'(addr)], 1'b0));
         end
      end
      idle_cycle();
      end_test();
   endtask

   //////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      rst_n_i          <= 1'b0;
      req_valid_i      <= 1'b0;
      req_i            <= '0;
      fromhost_valid_i <= 1'b0;
      fromhost_i       <= '0;
      err_cnt   = 0;
      test_errs = 0;
      test_cnt  = 0;
      pend      = 1'b0;
      pend_exp  = '0;
      cur_test  = "reset";
      void'($urandom(18817));
      repeat (4) @(posedge ram_clk);
      rst_n_i <= 1'b1;
      test_reset_idle();
      test_full_words();
      test_partial_writes();
      test_tohost();
      test_fromhost();
      test_miss();
      $display("tests run %0d, errors %0d", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== hw/io_subsys_top.sv ====
// IO side only: one requester, no back-pressure, responses exactly one cycle after each request
`timescale 1ns/1ps
`include "io_config.svh"

module io_subsys_top (
   input  logic                       ram_clk,
   input  logic                       rst_n_i,
   input  logic                       req_valid_i,
   input  io_pkg::io_req_t            req_i,
   output logic                       rsp_valid_o,
   output io_pkg::io_rsp_t            rsp_o,
   output logic                       tohost_valid_o,
   output logic [`IO_DATA_WIDTH-1:0]  tohost_o,
   input  logic                       fromhost_valid_i,
   input  logic [`IO_DATA_WIDTH-1:0]  fromhost_i,
   output logic                       irq_o
);

   logic            host_valid, bram_valid;
   io_pkg::io_req_t dev_req;
   logic            host_rsp_valid, bram_rsp_valid;
   io_pkg::io_rsp_t host_rsp, bram_rsp;

   //////////////////////////////////////////////////////////////
   // address decode

   io_addr_decoder u_decoder (
      .ram_clk          ( ram_clk        ),
      .rst_n_i          ( rst_n_i        ),
      .req_valid_i      ( req_valid_i    ),
      .req_i            ( req_i          ),
      .host_valid_o     ( host_valid     ),
      .bram_valid_o     ( bram_valid     ),
      .dev_req_o        ( dev_req        ),
      .host_rsp_valid_i ( host_rsp_valid ),
      .host_rsp_i       ( host_rsp       ),
      .bram_rsp_valid_i ( bram_rsp_valid ),
      .bram_rsp_i       ( bram_rsp       ),
      .rsp_valid_o      ( rsp_valid_o    ),
      .rsp_o            ( rsp_o          )
   );

   //////////////////////////////////////////////////////////////
   // devices

   bram_line_store u_bram (
      .ram_clk     ( ram_clk        ),
      .rst_n_i     ( rst_n_i        ),
      .req_valid_i ( bram_valid     ),
      .req_i       ( dev_req        ),
      .rsp_valid_o ( bram_rsp_valid ),
      .rsp_o       ( bram_rsp       )
   );

   host_mailbox u_host (
      .ram_clk          ( ram_clk          ),
      .rst_n_i          ( rst_n_i          ),
      .req_valid_i      ( host_valid       ),
      .req_i            ( dev_req          ),
      .rsp_valid_o      ( host_rsp_valid   ),
      .rsp_o            ( host_rsp         ),
      .tohost_valid_o   ( tohost_valid_o   ),
      .tohost_o         ( tohost_o         ),
      .fromhost_valid_i ( fromhost_valid_i ),
      .fromhost_i       ( fromhost_i       ),
      .irq_o            ( irq_o            )
   );

endmodule

// ==== hw/host_mailbox.sv ====
// tohost ignores byte strobes, fromhost is read-to-clear and a host load wins over a clearing read
`timescale 1ns/1ps
`include "io_config.svh"

module host_mailbox (
   input  logic                       ram_clk,
   input  logic                       rst_n_i,
   input  logic                       req_valid_i,
   input  io_pkg::io_req_t            req_i,
   output logic                       rsp_valid_o,
   output io_pkg::io_rsp_t            rsp_o,
   output logic                       tohost_valid_o,
   output logic [`IO_DATA_WIDTH-1:0]  tohost_o,
   input  logic                       fromhost_valid_i,
   input  logic [`IO_DATA_WIDTH-1:0]  fromhost_i,
   output logic                       irq_o
);

   localparam int OFS_BITS = $clog2(`IO_STRB_WIDTH);

   io_pkg::mbox_reg_e          reg_sel;
   logic                       wr_tohost, rd_fromhost;
   logic [`IO_DATA_WIDTH-1:0]  tohost_q, fromhost_q, rdata_q;

   assign reg_sel     = io_pkg::mbox_reg_e'(req_i.addr[OFS_BITS +: 2]);
   assign wr_tohost   = req_valid_i && (req_i.op == io_pkg::IO_WRITE)
                        && (reg_sel == io_pkg::MBOX_TOHOST);
   assign rd_fromhost = req_valid_i && (req_i.op == io_pkg::IO_READ)
                        && (reg_sel == io_pkg::MBOX_FROMHOST);

   //////////////////////////////////////////////////////////////
   // mailbox registers

   always_ff @(posedge ram_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tohost_q       <= '0;
         tohost_valid_o <= 1'b0;
         fromhost_q     <= '0;
         rsp_valid_o    <= 1'b0;
      end else begin
         tohost_valid_o <= wr_tohost;
         if (wr_tohost) begin
            tohost_q <= req_i.wdata;   // whole word
         end
         if (fromhost_valid_i) begin
            fromhost_q <= fromhost_i;
         end else if (rd_fromhost) begin
            fromhost_q <= '0;
         end
         rsp_valid_o <= req_valid_i;
      end
   end

   // read data, old fromhost value even when a load lands together
   always_ff @(posedge ram_clk) begin
      if (req_valid_i) begin
         rdata_q <= '0;
         if (req_i.op == io_pkg::IO_READ) begin
            case (reg_sel)
               io_pkg::MBOX_TOHOST:   rdata_q <= tohost_q;
               io_pkg::MBOX_FROMHOST: rdata_q <= fromhost_q;
               default:               rdata_q <= '0;   // unused offsets
            endcase
         end
      end
   end

   assign rsp_o.rdata = rdata_q;
   assign rsp_o.err   = 1'b0;
   assign tohost_o    = tohost_q;
   assign irq_o       = (fromhost_q != '0);

   //////////////////////////////////////////////////////////////
   // checks

   // irq one cycle after a load or a clearing read
   a_irq_update: assert property (
      @(posedge ram_clk) disable iff (!rst_n_i)
      (fromhost_valid_i || rd_fromhost) |=>
         (irq_o == ($past(fromhost_valid_i) && ($past(fromhost_i) != '0)))
   ) else $error("irq out of step with fromhost");

endmodule

// ==== hw/bram_line_store.sv ====
// wide-line block RAM, contents undefined until written; reads see writes from earlier cycles only
`timescale 1ns/1ps
`include "io_config.svh"

module bram_line_store (
   input  logic             ram_clk,
   input  logic             rst_n_i,
   input  logic             req_valid_i,
   input  io_pkg::io_req_t  req_i,
   output logic             rsp_valid_o,
   output io_pkg::io_rsp_t  rsp_o
);

   localparam int OFS_BITS  = $clog2(`IO_STRB_WIDTH);    // byte within word
   localparam int LANE_BITS = $clog2(`BRAM_LANES);       // word within line
   localparam int LINE_BITS = $clog2(`BRAM_LINES);
   localparam int LINE_STRB = `BRAM_LINE_WIDTH/8;

   logic [`BRAM_LINE_WIDTH-1:0] mem [0:`BRAM_LINES-1];

   logic [`BRAM_SIZE_BITS-1:0]  offset;
   logic [LINE_BITS-1:0]        line_idx, line_q;
   logic [LANE_BITS-1:0]        lane_idx, lane_q;
   logic [LINE_STRB-1:0]        strb_full;
   logic [`BRAM_LINE_WIDTH-1:0] wdata_full;
   logic [`BRAM_LINE_WIDTH-1:0] rd_line, rd_shifted;
   logic                        wr_q;

   //////////////////////////////////////////////////////////////
   // offset split and lane alignment

   assign offset   = req_i.addr[`BRAM_SIZE_BITS-1:0];
   assign line_idx = offset[`BRAM_SIZE_BITS-1 -: LINE_BITS];
   assign lane_idx = offset[OFS_BITS +: LANE_BITS];

   assign strb_full  = LINE_STRB'(req_i.strb) << {lane_idx, {OFS_BITS{1'b0}}};
   assign wdata_full = {`BRAM_LANES{req_i.wdata}};   // same word in every lane

   //////////////////////////////////////////////////////////////
   // storage

   always_ff @(posedge ram_clk) begin
      if (req_valid_i) begin
         line_q <= line_idx;
         lane_q <= lane_idx;
         if (req_i.op == io_pkg::IO_WRITE) begin
            for (int i = 0; i < LINE_STRB; i++) begin
               if (strb_full[i]) begin
                  mem[line_idx][i*8 +: 8] <= wdata_full[i*8 +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge ram_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rsp_valid_o <= 1'b0;
         wr_q        <= 1'b0;
      end else begin
         rsp_valid_o <= req_valid_i;
         if (req_valid_i) begin
            wr_q <= (req_i.op == io_pkg::IO_WRITE);
         end
      end
   end

   //////////////////////////////////////////////////////////////
   // read path, registered line shifted down by registered lane

   assign rd_line    = mem[line_q];
   assign rd_shifted = rd_line >> {lane_q, {(OFS_BITS+3){1'b0}}};

   assign rsp_o.rdata = wr_q ? '0 : rd_shifted[`IO_DATA_WIDTH-1:0];
   assign rsp_o.err   = 1'b0;

   //////////////////////////////////////////////////////////////
   // checks

   a_strobe_known: assert property (
      @(posedge ram_clk) disable iff (!rst_n_i)
      !$isunknown(req_valid_i)
   ) else $error("bram strobe unknown");

   a_write_has_bytes: assert property (
      @(posedge ram_clk) disable iff (!rst_n_i)
      (req_valid_i && req_i.op == io_pkg::IO_WRITE) |-> (req_i.strb != '0)
   ) else $error("bram write with no byte enabled");

endmodule

// ==== hw/io_addr_decoder.sv ====
// routes by base/mask to the mailbox or block RAM; devices must answer exactly one cycle later
`timescale 1ns/1ps
`include "io_config.svh"

module io_addr_decoder (
   input  logic             ram_clk,
   input  logic             rst_n_i,
   input  logic             req_valid_i,
   input  io_pkg::io_req_t  req_i,
   output logic             host_valid_o,
   output logic             bram_valid_o,
   output io_pkg::io_req_t  dev_req_o,
   input  logic             host_rsp_valid_i,
   input  io_pkg::io_rsp_t  host_rsp_i,
   input  logic             bram_rsp_valid_i,
   input  io_pkg::io_rsp_t  bram_rsp_i,
   output logic             rsp_valid_o,
   output io_pkg::io_rsp_t  rsp_o
);

   io_pkg::dev_sel_e dev_sel, dev_sel_q;
   logic             miss_q;   // error response pending
   logic             host_hit, bram_hit;

   //////////////////////////////////////////////////////////////
   // request side, combinational

   assign host_hit = ((req_i.addr & ~`HOST_MASK) == `HOST_BASE);
   assign bram_hit = ((req_i.addr & ~`BRAM_MASK) == `BRAM_BASE);

   always_comb begin
      if (host_hit) begin
         dev_sel = io_pkg::DEV_HOST;
      end else if (bram_hit) begin
         dev_sel = io_pkg::DEV_BRAM;
      end else begin
         dev_sel = io_pkg::DEV_NONE;
      end
   end

   assign host_valid_o = req_valid_i && (dev_sel == io_pkg::DEV_HOST);
   assign bram_valid_o = req_valid_i && (dev_sel == io_pkg::DEV_BRAM);

   // devices only see the offset inside their window
   always_comb begin
      dev_req_o = req_i;
      unique case (dev_sel)
         io_pkg::DEV_HOST: dev_req_o.addr = req_i.addr & `HOST_MASK;
         io_pkg::DEV_BRAM: dev_req_o.addr = req_i.addr & `BRAM_MASK;
         default:          dev_req_o.addr = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////
   // one stage of select and miss tracking

   always_ff @(posedge ram_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dev_sel_q <= io_pkg::DEV_NONE;
         miss_q    <= 1'b0;
      end else begin
         if (req_valid_i) begin
            dev_sel_q <= dev_sel;
         end
         miss_q <= req_valid_i && (dev_sel == io_pkg::DEV_NONE);
      end
   end

   //////////////////////////////////////////////////////////////
   // response return mux

   always_comb begin
      rsp_valid_o = 1'b0;
      rsp_o       = '0;
      unique case (dev_sel_q)
         io_pkg::DEV_HOST: begin
            rsp_valid_o = host_rsp_valid_i;
            rsp_o       = host_rsp_i;
         end
         io_pkg::DEV_BRAM: begin
            rsp_valid_o = bram_rsp_valid_i;
            rsp_o       = bram_rsp_i;
         end
         default: begin
            rsp_valid_o = miss_q;
            rsp_o.err   = 1'b1;   // data stays zero
         end
      endcase
   end

   //////////////////////////////////////////////////////////////
   // checks

   // overlapping windows would hand a request to the host only
   a_windows_disjoint: assert property (
      @(posedge ram_clk) disable iff (!rst_n_i)
      req_valid_i |-> !(host_hit && bram_hit)
   ) else $error("request matches both device windows");

   // a device answer must line up with its own strobe one cycle earlier
   a_host_rsp_timing: assert property (
      @(posedge ram_clk) disable iff (!rst_n_i)
      host_rsp_valid_i |-> $past(host_valid_o)
   ) else $error("host response without request one cycle earlier");

   a_bram_rsp_timing: assert property (
      @(posedge ram_clk) disable iff (!rst_n_i)
      bram_rsp_valid_i |-> $past(bram_valid_o)
   ) else $error("bram response without request one cycle earlier");

endmodule

// ==== hw/io_pkg.sv ====
// request/response types of the single-cycle IO bus; widths come from io_config.svh
`include "io_config.svh"

package io_pkg;

   //////////////////////////////////////////////////////////////
   // opcodes and selects

   typedef enum logic {
      IO_READ  = 1'b0,
      IO_WRITE = 1'b1
   } io_op_e;

   typedef enum logic [1:0] {
      DEV_HOST = 2'd0,
      DEV_BRAM = 2'd1,
      DEV_NONE = 2'd2
   } dev_sel_e;

   // word offsets inside the mailbox window
   typedef enum logic [1:0] {
      MBOX_TOHOST   = 2'd0,
      MBOX_FROMHOST = 2'd1
   } mbox_reg_e;

   //////////////////////////////////////////////////////////////
   // bus payloads

   // 69 bits with the default widths
   typedef struct packed {
      io_op_e                      op;
      logic [`IO_ADDR_WIDTH-1:0]   addr;
      logic [`IO_DATA_WIDTH-1:0]   wdata;
      logic [`IO_STRB_WIDTH-1:0]   strb;
   } io_req_t;

   typedef struct packed {
      logic [`IO_DATA_WIDTH-1:0]   rdata;
      logic                        err;   // address miss
   } io_rsp_t;

endpackage

// ==== hw/io_config.svh ====
// bus widths, block RAM geometry and the IO address map; windows must be aligned to their mask
`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

//////////////////////////////////////////////////////////////
// bus widths
`define IO_ADDR_WIDTH   32
`define IO_DATA_WIDTH   32
`define IO_STRB_WIDTH   (`IO_DATA_WIDTH/8)

//////////////////////////////////////////////////////////////
// block RAM geometry
`define BRAM_SIZE_BITS  12                  // 2^12 -> 4 KB
`define BRAM_LINE_WIDTH 128                 // one storage line
`define BRAM_LANES      (`BRAM_LINE_WIDTH/`IO_DATA_WIDTH)
`define BRAM_LINES      ((2**`BRAM_SIZE_BITS)/(`BRAM_LINE_WIDTH/8))

//////////////////////////////////////////////////////////////
// device address map, base/mask pairs
`define HOST_BASE       32'h0000_1000
`define HOST_MASK       32'h0000_000F
`define BRAM_BASE       32'h0001_0000
`define BRAM_MASK       32'h0000_0FFF

`endif
